// File: include/vna_dsp_macros.svh
`ifndef VNA_DSP_MACROS_SVH
`define VNA_DSP_MACROS_SVH

`define SAMPLE_W       16
`define MAG_W          18  // Headroom for CORDIC gain
`define PHASE_W        16  // One turn is 2^16 counts
`define FIR_TAPS       15
`define FIR_SHIFT      6   // Tap weights sum to 64
`define CORDIC_STAGES  12
`define AVG_LOG2       4   // 16 frames per block

`endif

// File: src/vna_dsp_pkg.sv
package vna_dsp_pkg;

    `include "vna_dsp_macros.svh"

    // Complex sample from the ADC path
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] i;
        logic signed [`SAMPLE_W-1:0] q;
    } iq_t;

    typedef struct packed {
        logic [`MAG_W-1:0]   mag;
        logic [`PHASE_W-1:0] phase;  // Unsigned turn fraction
    } polar_t;

    // Averaged S-parameter, phase of b relative to a
    typedef struct packed {
        logic [`MAG_W-1:0]          mag;
        logic signed [`PHASE_W-1:0] phase;
    } coeff_t;

    // atan(2^-k) in 1/65536 turn
    localparam logic [`PHASE_W-1:0] cordic_atan [`CORDIC_STAGES] = '{
        16'd8192, 16'd4836, 16'd2555, 16'd1297,
        16'd651,  16'd326,  16'd163,  16'd81,
        16'd41,   16'd20,   16'd10,   16'd5
    };

endpackage

// File: src/fir_15.sv
`include "vna_dsp_macros.svh"

module fir_15 (
    input  logic             aclk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  vna_dsp_pkg::iq_t in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output vna_dsp_pkg::iq_t out_data
);
    import vna_dsp_pkg::*;

    localparam int ACC_W = `SAMPLE_W + `FIR_SHIFT + 1;

    iq_t hist [`FIR_TAPS-1];    // Older samples, hist[0] is the most recent
    iq_t window [`FIR_TAPS];    // New sample plus history
    logic signed [ACC_W-1:0] sum_i;
    logic signed [ACC_W-1:0] sum_q;
    logic take;

    // Triangular taps 1..8..1
    function automatic logic signed [ACC_W-1:0] tap_weight(input int k);
        return (k < `FIR_TAPS / 2) ? ACC_W'(k + 1) : ACC_W'(`FIR_TAPS - k);
    endfunction

    assign in_ready = out_ready || !out_valid;
    assign take     = in_valid && in_ready;

    always_comb begin
        window[0] = in_data;
        for (int k = 1; k < `FIR_TAPS; k++) begin
            window[k] = hist[k-1];
        end
    end

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            sum_i = sum_i + ACC_W'(window[k].i) * tap_weight(k);
            sum_q = sum_q + ACC_W'(window[k].q) * tap_weight(k);
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid <= 1'b0;
            for (int k = 0; k < `FIR_TAPS - 1; k++) begin
                hist[k] <= '0;
            end
        end else if (take) begin
            out_valid <= 1'b1;
            for (int k = 0; k < `FIR_TAPS - 1; k++) begin
                hist[k] <= window[k];  // Shift by one
            end
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            out_data.i <= `SAMPLE_W'(sum_i >>> `FIR_SHIFT);
            out_data.q <= `SAMPLE_W'(sum_q >>> `FIR_SHIFT);
        end
    end

    a_hold_stalled: assert property (@(posedge aclk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

// File: src/cordic.sv
`include "vna_dsp_macros.svh"

module cordic (
    input  logic                aclk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  vna_dsp_pkg::iq_t    in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output vna_dsp_pkg::polar_t out_data
);
    import vna_dsp_pkg::*;

    localparam int LAST = `CORDIC_STAGES;

    // Rank 0 is the quadrant fold, ranks 1..LAST are the rotations
    logic signed [`MAG_W-1:0] x [LAST+1];
    logic signed [`MAG_W-1:0] y [LAST+1];
    logic [`PHASE_W-1:0]      z [LAST+1];
    logic [LAST:0]            v;
    logic                     advance;
    logic signed [`MAG_W-1:0] in_x;
    logic signed [`MAG_W-1:0] in_y;

    assign advance  = out_ready || !v[LAST];  // Freeze only when the output is stuck
    assign in_ready = advance;

    assign in_x = `MAG_W'(in_data.i);  // Sign extend
    assign in_y = `MAG_W'(in_data.q);

    always_ff @(posedge aclk) begin
        if (reset) begin
            v <= '0;
        end else if (advance) begin
            v <= {v[LAST-1:0], in_valid};
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            // Left half plane gets rotated by a half turn first
            if (in_data.i[`SAMPLE_W-1]) begin
                x[0] <= -in_x;
                y[0] <= -in_y;
                z[0] <= {1'b1, {(`PHASE_W-1){1'b0}}};
            end else begin
                x[0] <= in_x;
                y[0] <= in_y;
                z[0] <= '0;
            end

            for (int k = 0; k < LAST; k++) begin
                if (!y[k][`MAG_W-1]) begin
                    x[k+1] <= x[k] + (y[k] >>> k);
                    y[k+1] <= y[k] - (x[k] >>> k);
                    z[k+1] <= z[k] + cordic_atan[k];
                end else begin
                    x[k+1] <= x[k] - (y[k] >>> k);
                    y[k+1] <= y[k] + (x[k] >>> k);
                    z[k+1] <= z[k] - cordic_atan[k];
                end
            end
        end
    end

    assign out_valid      = v[LAST];
    assign out_data.mag   = $unsigned(x[LAST]);  // Includes the gain of about 1.647
    assign out_data.phase = z[LAST];

    // A stalled result blocks the input and stays put
    a_stall_freeze: assert property (@(posedge aclk) disable iff (reset)
        out_valid && !out_ready |-> !in_ready ##1 (out_valid && $stable(out_data)));

endmodule

// File: src/coeff_accum.sv
`include "vna_dsp_macros.svh"

module coeff_accum (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               add,
    input  logic                               first,
    input  vna_dsp_pkg::polar_t                b_wave,
    input  vna_dsp_pkg::polar_t                a_wave,
    output logic [`MAG_W+`AVG_LOG2-1:0]        mag_sum,
    output logic signed [`PHASE_W+`AVG_LOG2-1:0] phase_sum
);
    localparam int MSUM_W = `MAG_W + `AVG_LOG2;
    localparam int PSUM_W = `PHASE_W + `AVG_LOG2;

    logic signed [`PHASE_W-1:0] phase_diff;

    // Modular subtraction, read back as signed gives the short way round
    assign phase_diff = b_wave.phase - a_wave.phase;

    always_ff @(posedge aclk) begin
        if (reset) begin
            mag_sum   <= '0;
            phase_sum <= '0;
        end else if (add) begin
            if (first) begin  // Start of a new block
                mag_sum   <= MSUM_W'(b_wave.mag);
                phase_sum <= PSUM_W'(phase_diff);
            end else begin
                mag_sum   <= mag_sum + MSUM_W'(b_wave.mag);
                phase_sum <= phase_sum + PSUM_W'(phase_diff);
            end
        end
    end

endmodule

// File: src/coeff_average.sv
`include "vna_dsp_macros.svh"

module coeff_average (
    input  logic                aclk,
    input  logic                reset,
    input  logic [3:0]          in_valid,
    output logic [3:0]          in_ready,
    input  vna_dsp_pkg::polar_t in_data [4],
    output logic                coeff_valid,
    input  logic                coeff_ready,
    output vna_dsp_pkg::coeff_t s11,
    output vna_dsp_pkg::coeff_t s12,
    output vna_dsp_pkg::coeff_t s21,
    output vna_dsp_pkg::coeff_t s22
);
    import vna_dsp_pkg::*;

    localparam int MSUM_W = `MAG_W + `AVG_LOG2;
    localparam int PSUM_W = `PHASE_W + `AVG_LOG2;

    // Pair order s11, s12, s21, s22 with channels a1=0 b1=1 a2=2 b2=3
    localparam int B_CH [4] = '{1, 1, 3, 3};
    localparam int A_CH [4] = '{0, 2, 0, 2};

    logic [`AVG_LOG2-1:0]     cnt;
    logic                     frame;
    logic                     first;
    logic                     done;  // Last frame of a block went into the sums
    logic [MSUM_W-1:0]        mag_sum [4];
    logic signed [PSUM_W-1:0] phase_sum [4];

    function automatic coeff_t scale(input logic [MSUM_W-1:0] m,
                                     input logic signed [PSUM_W-1:0] p);
        coeff_t c;
        c.mag   = `MAG_W'(m >> `AVG_LOG2);
        c.phase = `PHASE_W'(p >>> `AVG_LOG2);
        return c;
    endfunction

    assign frame    = (&in_valid) && !coeff_valid;  // All four advance together
    assign in_ready = {4{frame}};
    assign first    = (cnt == '0);

    for (genvar p = 0; p < 4; p++) begin : g_pair
        coeff_accum acc (
            .aclk      (aclk),
            .reset     (reset),
            .add       (frame),
            .first     (first),
            .b_wave    (in_data[B_CH[p]]),
            .a_wave    (in_data[A_CH[p]]),
            .mag_sum   (mag_sum[p]),
            .phase_sum (phase_sum[p])
        );
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            cnt         <= '0;
            done        <= 1'b0;
            coeff_valid <= 1'b0;
        end else begin
            done <= frame && (&cnt);
            if (frame) cnt <= cnt + 1'b1;
            if (done) begin
                coeff_valid <= 1'b1;
            end else if (coeff_ready) begin
                coeff_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (done) begin
            s11 <= scale(mag_sum[0], phase_sum[0]);
            s12 <= scale(mag_sum[1], phase_sum[1]);
            s21 <= scale(mag_sum[2], phase_sum[2]);
            s22 <= scale(mag_sum[3], phase_sum[3]);
        end
    end

    // Held result blocks all inputs and keeps its value
    a_hold_result: assert property (@(posedge aclk) disable iff (reset)
        coeff_valid && !coeff_ready |-> in_ready == '0
            ##1 (coeff_valid && $stable({s11, s12, s21, s22})));

endmodule

// File: src/vna_dsp_top.sv
module vna_dsp_top (
    input  logic                aclk,
    input  logic                reset,

    input  logic                a1_valid,  // Port 1 forward
    output logic                a1_ready,
    input  vna_dsp_pkg::iq_t    a1_data,
    input  logic                b1_valid,  // Port 1 reverse
    output logic                b1_ready,
    input  vna_dsp_pkg::iq_t    b1_data,
    input  logic                a2_valid,  // Port 2 forward
    output logic                a2_ready,
    input  vna_dsp_pkg::iq_t    a2_data,
    input  logic                b2_valid,  // Port 2 reverse
    output logic                b2_ready,
    input  vna_dsp_pkg::iq_t    b2_data,

    output logic                coeff_valid,
    input  logic                coeff_ready,
    output vna_dsp_pkg::coeff_t s11,
    output vna_dsp_pkg::coeff_t s12,
    output vna_dsp_pkg::coeff_t s21,
    output vna_dsp_pkg::coeff_t s22
);
    import vna_dsp_pkg::*;

    logic [3:0] ch_valid;
    logic [3:0] ch_ready;
    iq_t        ch_data [4];

    logic [3:0] fir_valid;
    logic [3:0] fir_ready;
    iq_t        fir_data [4];

    logic [3:0] cor_valid;
    logic [3:0] cor_ready;
    polar_t     cor_data [4];

    // Channel order a1, b1, a2, b2
    assign ch_valid = {b2_valid, a2_valid, b1_valid, a1_valid};
    assign ch_data  = '{a1_data, b1_data, a2_data, b2_data};
    assign a1_ready = ch_ready[0];
    assign b1_ready = ch_ready[1];
    assign a2_ready = ch_ready[2];
    assign b2_ready = ch_ready[3];

    for (genvar ch = 0; ch < 4; ch++) begin : g_chan
        fir_15 fir (
            .aclk      (aclk),
            .reset     (reset),
            .in_valid  (ch_valid[ch]),
            .in_ready  (ch_ready[ch]),
            .in_data   (ch_data[ch]),
            .out_valid (fir_valid[ch]),
            .out_ready (fir_ready[ch]),
            .out_data  (fir_data[ch])
        );

        cordic cord (
            .aclk      (aclk),
            .reset     (reset),
            .in_valid  (fir_valid[ch]),
            .in_ready  (fir_ready[ch]),
            .in_data   (fir_data[ch]),
            .out_valid (cor_valid[ch]),
            .out_ready (cor_ready[ch]),
            .out_data  (cor_data[ch])
        );
    end

    coeff_average avg (
        .aclk        (aclk),
        .reset       (reset),
        .in_valid    (cor_valid),
        .in_ready    (cor_ready),
        .in_data     (cor_data),
        .coeff_valid (coeff_valid),
        .coeff_ready (coeff_ready),
        .s11         (s11),
        .s12         (s12),
        .s21         (s21),
        .s22         (s22)
    );

endmodule

// File: test/vna_dsp_tb.sv
`include "vna_dsp_macros.svh"

module vna_dsp_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vna_dsp_pkg::*;

    localparam int N_TESTS  = 5;
    localparam int SAMPLES  = 160;  // Per channel and test
    localparam int SETS     = SAMPLES >> `AVG_LOG2;
    localparam int WATCH_NS = N_TESTS * SAMPLES * 8 * 20 + 20000;
    localparam int B_WAVE [4] = '{1, 1, 3, 3};  // s11 s12 s21 s22
    localparam int A_WAVE [4] = '{0, 2, 0, 2};
    localparam int TONE_I [4] = '{12000, 0, -7000, 5000};
    localparam int TONE_Q [4] = '{0, 9000, -7000, -11000};
    localparam int WRAP_I [4] = '{-1000, -1000, 1000, 1000};  // Just either side of the wraps
    localparam int WRAP_Q [4] = '{50, -50, -50, 50};

    logic       aclk = 1'b0;
    logic       reset;
    logic [3:0] valid;
    logic [3:0] ready;
    iq_t        data [4];
    logic       coeff_valid;
    logic       coeff_ready;
    coeff_t     s_out [4];
    string      s_name [4] = '{"s11", "s12", "s21", "s22"};

    int         seed = 52;
    int         mode;
    int         left [4];
    logic [3:0] taken;
    int         errors;
    int         passes;
    int         fails;
    int         sets_seen;
    int         set_in_test;

    int         hist_i [4][`FIR_TAPS];  // [0] is the newest accepted sample
    int         hist_q [4][`FIR_TAPS];
    polar_t     wave_q [4][$];
    coeff_t     expect_q [4][$];
    int         frames;
    int         mag_acc [4];
    int         phase_acc [4];
    logic       stalled;
    coeff_t     held [4];

    vna_dsp_top dut (
        .aclk        (aclk),
        .reset       (reset),
        .a1_valid    (valid[0]), .a1_ready (ready[0]), .a1_data (data[0]),
        .b1_valid    (valid[1]), .b1_ready (ready[1]), .b1_data (data[1]),
        .a2_valid    (valid[2]), .a2_ready (ready[2]), .a2_data (data[2]),
        .b2_valid    (valid[3]), .b2_ready (ready[3]), .b2_data (data[3]),
        .coeff_valid (coeff_valid),
        .coeff_ready (coeff_ready),
        .s11         (s_out[0]),
        .s12         (s_out[1]),
        .s21         (s_out[2]),
        .s22         (s_out[3])
    );

    always #10 aclk = ~aclk;

    function automatic int wrap(input int v, input int w);
        int m;
        m = v & ((1 << w) - 1);
        return (m >= (1 << (w - 1))) ? m - (1 << w) : m;
    endfunction

    function automatic int fir_tap(input int k);
        return (k + 1 < `FIR_TAPS - k) ? k + 1 : `FIR_TAPS - k;
    endfunction

    function automatic polar_t cordic_model(input int i, input int q);
        int x;
        int y;
        int z;
        int xn;
        polar_t r;
        x = (i < 0) ? -i : i;  // Fold the left half plane
        y = (i < 0) ? -q : q;
        z = (i < 0) ? 32768 : 0;
        for (int k = 0; k < `CORDIC_STAGES; k++) begin
            if (y >= 0) begin
                xn = x + (y >>> k);
                y  = y - (x >>> k);
                z  = z + int'(cordic_atan[k]);
            end else begin
                xn = x - (y >>> k);
                y  = y + (x >>> k);
                z  = z - int'(cordic_atan[k]);
            end
            x = wrap(xn, `MAG_W);
            y = wrap(y, `MAG_W);
        end
        r.mag   = `MAG_W'(x);
        r.phase = `PHASE_W'(z);
        return r;
    endfunction

    function automatic iq_t next_sample(input int ch);
        iq_t s;
        case (mode)
            2: begin
                s.i = 16'(TONE_I[ch]);
                s.q = 16'(TONE_Q[ch]);
            end
            5: begin
                s.i = 16'(WRAP_I[ch]);
                s.q = 16'(WRAP_Q[ch]);
            end
            default: begin
                s.i = 16'($random(seed));
                s.q = 16'($random(seed));
            end
        endcase
        return s;
    endfunction

    task automatic accept(input int ch, input iq_t s);
        int si;
        int sq;
        for (int k = `FIR_TAPS - 1; k > 0; k--) begin
            hist_i[ch][k] = hist_i[ch][k-1];
            hist_q[ch][k] = hist_q[ch][k-1];
        end
        hist_i[ch][0] = int'(s.i);
        hist_q[ch][0] = int'(s.q);
        si = 0;
        sq = 0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            si += hist_i[ch][k] * fir_tap(k);
            sq += hist_q[ch][k] * fir_tap(k);
        end
        wave_q[ch].push_back(cordic_model(wrap(si >>> `FIR_SHIFT, `SAMPLE_W),
                                          wrap(sq >>> `FIR_SHIFT, `SAMPLE_W)));
    endtask

    // Frames join the oldest polar value of every channel
    task automatic combine();
        polar_t w [4];
        int d;
        coeff_t c;
        while (wave_q[0].size() > 0 && wave_q[1].size() > 0 &&
               wave_q[2].size() > 0 && wave_q[3].size() > 0) begin
            for (int ch = 0; ch < 4; ch++) begin
                w[ch] = wave_q[ch].pop_front();
            end
            for (int p = 0; p < 4; p++) begin
                d = wrap(int'(w[B_WAVE[p]].phase) - int'(w[A_WAVE[p]].phase), `PHASE_W);
                mag_acc[p]   = (frames == 0) ? 0 : mag_acc[p];
                phase_acc[p] = (frames == 0) ? 0 : phase_acc[p];
                mag_acc[p]   += int'(w[B_WAVE[p]].mag);
                phase_acc[p] += d;
            end
            frames++;
            if (frames == (1 << `AVG_LOG2)) begin
                for (int p = 0; p < 4; p++) begin
                    c.mag   = `MAG_W'(mag_acc[p] >> `AVG_LOG2);
                    c.phase = `PHASE_W'(phase_acc[p] >>> `AVG_LOG2);
                    expect_q[p].push_back(c);
                end
                frames = 0;
            end
        end
    endtask

    task automatic check_set();
        coeff_t e;
        if (expect_q[0].size() == 0) begin
            $display("coefficient set at %0t arrived while none was expected", $time);
            errors++;
            return;
        end
        for (int p = 0; p < 4; p++) begin
            e = expect_q[p].pop_front();
            if (s_out[p] !== e) begin
                $display("mismatch at %0t: %s got mag %0d phase %0d, expected mag %0d phase %0d",
                         $time, s_name[p], s_out[p].mag, s_out[p].phase, e.mag, e.phase);
                errors++;
            end
        end
        // Same-port pairs sit a few degrees apart across a wrap
        if (mode == 5 && set_in_test > 0) begin
            for (int p = 0; p < 4; p += 3) begin
                if (s_out[p].phase <= 0 || s_out[p].phase >= 2048) begin
                    $display("%s phase %0d at %0t did not take the short way round",
                             s_name[p], s_out[p].phase, $time);
                    errors++;
                end
            end
        end
        sets_seen++;
        set_in_test++;
    endtask

    always @(posedge aclk) begin
        if (!reset) begin
            for (int ch = 0; ch < 4; ch++) begin
                if (valid[ch] && ready[ch]) begin
                    accept(ch, data[ch]);
                    taken[ch] = 1'b1;
                end
            end
            combine();
            if (stalled) begin
                if (!coeff_valid) begin
                    $display("coeff_valid dropped at %0t before its transfer", $time);
                    errors++;
                end
                for (int p = 0; p < 4; p++) begin
                    if (s_out[p] !== held[p]) begin
                        $display("mismatch at %0t: %s changed under stall, got %h, expected %h",
                                 $time, s_name[p], s_out[p], held[p]);
                        errors++;
                    end
                end
            end
            stalled = coeff_valid && !coeff_ready;
            held    = s_out;
            if (coeff_valid && coeff_ready) check_set();
        end
    end

    always @(negedge aclk) begin
        for (int ch = 0; ch < 4; ch++) begin
            if (!valid[ch] || taken[ch]) begin
                taken[ch] = 1'b0;
                valid[ch] = 1'b0;
                if (left[ch] > 0 && (mode == 2 || ($random(seed) & 3) != 0)) begin
                    valid[ch] = 1'b1;
                    data[ch]  = next_sample(ch);
                    left[ch]--;
                end
            end
        end
        coeff_ready = (mode == 4) ? 1'($random(seed)) : 1'b1;
    end

    task automatic finish_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            passes++;
            $display("test %0d %s: passed", num, name);
        end else begin
            fails++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
        end
    endtask

    task automatic check_idle(input string when);
        if (coeff_valid !== 1'b0) begin
            $display("mismatch at %0t: coeff_valid %s got %b, expected 0", $time, when,
                     coeff_valid);
            errors++;
        end
        if (ready !== 4'hf) begin
            $display("mismatch at %0t: b2..a1_ready %s got %b, expected 1111", $time, when,
                     ready);
            errors++;
        end
    endtask

    task automatic run_stream(input int m, input string name);
        int err_before;
        int target;
        err_before = errors;
        @(posedge aclk);
        target      = sets_seen + SETS;
        set_in_test = 0;
        mode        = m;
        for (int ch = 0; ch < 4; ch++) begin
            left[ch] = SAMPLES;
        end
        while (sets_seen < target) @(negedge aclk);
        repeat (40) @(negedge aclk);  // Room for a surplus set to show up
        if (sets_seen != target) begin
            $display("%s gave %0d coefficient sets instead of %0d", name,
                     sets_seen - target + SETS, SETS);
            errors++;
        end
        finish_test(m, name, err_before);
    endtask

    initial begin
        reset       = 1'b1;
        valid       = '0;
        taken       = '0;
        coeff_ready = 1'b1;
        stalled     = 1'b0;
        mode        = 0;
        for (int ch = 0; ch < 4; ch++) begin
            data[ch] = '0;
            left[ch] = 0;
        end
        for (int n = 1; n <= 16; n++) begin
            @(posedge aclk);
            if (n > 1) check_idle("during reset");
        end
        @(negedge aclk);
        reset = 1'b0;
        @(posedge aclk);
        check_idle("after reset");
        finish_test(1, "reset", 0);
        run_stream(2, "steady tone");
        run_stream(3, "random stream");
        run_stream(4, "back-pressure");
        run_stream(5, "phase wrap");
        $display("tests passed %0d, failed %0d, errors %0d", passes, fails, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCH_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: vna_dsp_top.f
+incdir+include
src/vna_dsp_pkg.sv
src/fir_15.sv
src/cordic.sv
src/coeff_accum.sv
src/coeff_average.sv
src/vna_dsp_top.sv
test/vna_dsp_tb.sv

// File: Makefile
TOP = vna_dsp_tb
SRCS = $(wildcard src/*.sv) $(wildcard test/*.sv) include/vna_dsp_macros.svh

all: run

obj_dir/V$(TOP): vna_dsp_top.f $(SRCS)
	verilator --binary --assert -j 0 --top-module $(TOP) -f vna_dsp_top.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^PASS: all tests$$" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f vna_dsp_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
